// File: pwr_ctrl.f
src/pwr_ctrl_pkg.sv
src/pwr_req_capture.sv
src/pwr_esc_monitor.sv
src/pwr_fast_fsm.sv
src/pwr_ctrl.sv
dv/tb_pwr_ctrl.sv

// File: Bender.yml
package:
  name: pwr_ctrl

sources:
  - src/pwr_ctrl_pkg.sv
  - src/pwr_req_capture.sv
  - src/pwr_esc_monitor.sv
  - src/pwr_fast_fsm.sv
  - src/pwr_ctrl.sv
  - target: test
    files:
      - dv/tb_pwr_ctrl.sv

// File: dv/tb_pwr_ctrl.sv
// directed testbench for the power controller
// runs reset, sleep and wakeup, fall-through, resets, escalation and heartbeat tests
`timescale 1ns/1ps

module tb_pwr_ctrl
  import pwr_ctrl_pkg::*;
();

  logic                    clk_i = 1'b0;
  logic                    effective_rst_n;
  logic [NumWkups-1:0]     wakeups_i, wakeup_en_i;
  logic [NumRstReqs-1:0]   rstreqs_i, reset_en_i;
  logic                    ndmreset_req_i, sw_rst_req_i;
  logic                    esc_req_i, esc_ping_i, esc_timeout_o;
  logic                    core_sleeping_i, low_power_hint_i;
  logic                    clk_en_o, low_power_o, intr_wakeup_o, cfg_regwen_o;
  pwr_rst_t                pwr_rst_o;
  wake_info_t              wake_info_o;
  logic [TotalRstReqs-1:0] reset_cause_o;
  logic [31:0]             lcg_state = 32'hba71;
  bit                      ping_en = 1'b1;
  int                      ping_cnt = 0;

  pwr_ctrl dut0 (.*);

  always #50 clk_i = ~clk_i;

  // heartbeat, one pulse every 20 cycles
  always @(posedge clk_i) begin
    #1;
    if (ping_en && ping_cnt == 19) begin
      esc_ping_i = 1'b1;
      ping_cnt   = 0;
    end else begin
      esc_ping_i = 1'b0;
      ping_cnt   = ping_en ? ping_cnt + 1 : 0;
    end
  end

  //////////////////////////////
  // helpers
  //////////////////////////////

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    // upper bits are the better ones
    return lcg_state >> 16;
  endfunction

  task automatic next_cycle();
    @(posedge clk_i);
    #1;
  endtask

  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    if (actual !== expected) begin
      $display("FAILED at time %0t: %s, got 'h%0h, expected 'h%0h",
               $time, what, actual, expected);
      $display("sim failed");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic timeout_abort(input string what);
    $display("timeout at time %0t: %s", $time, what);
    $display("sim failed");
    $fatal(1, "wait timed out");
  endtask

  // escalation latch is sticky, so every test starts here
  task automatic apply_reset();
    ping_en          = 1'b1;
    effective_rst_n  = 1'b0;
    wakeups_i        = '0;
    wakeup_en_i      = '0;
    rstreqs_i        = '0;
    reset_en_i       = '0;
    ndmreset_req_i   = 1'b0;
    sw_rst_req_i     = 1'b0;
    esc_req_i        = 1'b0;
    core_sleeping_i  = 1'b0;
    low_power_hint_i = 1'b0;
    repeat (8) @(posedge clk_i);
    #1;
    effective_rst_n = 1'b1;
  endtask

  task automatic enter_low_power();
    int n;
    n = 0;
    core_sleeping_i  = 1'b1;
    low_power_hint_i = 1'b1;
    while (!low_power_o) begin
      next_cycle();
      n++;
      if (n > 10) timeout_abort("low_power_o never rose after the entry request");
    end
    check_value(clk_en_o, 0, "clk_en_o in low power");
    check_value(cfg_regwen_o, 0, "cfg_regwen_o locked in low power");
    // drop the request so the wakeup does not re-enter
    core_sleeping_i  = 1'b0;
    low_power_hint_i = 1'b0;
  endtask

  // waits for a reset request, then counts its length
  task automatic measure_reset(output int high, output int lc,
                               output logic [TotalRstReqs-1:0] cause);
    int n;
    n     = 0;
    high  = 0;
    lc    = 0;
    cause = '0;
    while (!pwr_rst_o.rst_sys_req) begin
      next_cycle();
      n++;
      if (n > 20) timeout_abort("rst_sys_req never rose");
    end
    while (pwr_rst_o.rst_sys_req) begin
      high++;
      if (pwr_rst_o.rst_lc_req) lc++;
      cause = reset_cause_o;
      next_cycle();
      if (high > 40) timeout_abort("rst_sys_req never fell");
    end
  endtask

  //////////////////////////////
  // tests
  //////////////////////////////

  task automatic test_after_reset();
    apply_reset();
    check_value(clk_en_o, 1, "clk_en_o after reset");
    check_value(cfg_regwen_o, 1, "cfg_regwen_o after reset");
    check_value({low_power_o, intr_wakeup_o, pwr_rst_o, esc_timeout_o}, 0,
                "control outputs after reset");
    check_value(wake_info_o, 0, "wake_info_o after reset");
    check_value(reset_cause_o, 0, "reset_cause_o after reset");
  endtask

  task automatic test_sleep_wakeup();
    logic [NumWkups-1:0] en, v;
    int n;
    apply_reset();
    // need some enabled and some disabled sources
    en = lcg_next();
    if (en == '0) en = 4'b0001;
    if (en == '1) en = 4'b0111;
    wakeup_en_i = en;
    enter_low_power();
    v = lcg_next() & ~en;
    if (v == '0) v = ~en;
    wakeups_i = v;
    repeat (20) begin
      next_cycle();
      check_value(low_power_o, 1, "disabled wakeup left low power");
    end
    v = lcg_next();
    if ((v & en) == '0) v = v | en;
    wakeups_i = v;
    n = 0;
    while (!intr_wakeup_o) begin
      next_cycle();
      n++;
      if (n > 10) timeout_abort("intr_wakeup_o never pulsed after an enabled wakeup");
    end
    check_value(n, 2, "wakeup pin to interrupt latency");
    check_value(wake_info_o.reasons, v & en, "wake reasons");
    check_value({low_power_o, clk_en_o, cfg_regwen_o}, 3'b011, "state after wakeup");
    next_cycle();
    check_value(intr_wakeup_o, 0, "interrupt longer than one cycle");
    wakeups_i = '0;
  endtask

  task automatic test_fall_through();
    logic [NumWkups-1:0] en, v;
    apply_reset();
    en = lcg_next();
    if (en == '0) en = 4'b1000;
    v = lcg_next();
    if ((v & en) == '0) v = v | en;
    wakeup_en_i = en;
    wakeups_i   = v;
    repeat (2) next_cycle();
    core_sleeping_i  = 1'b1;
    low_power_hint_i = 1'b1;
    repeat (10) begin
      next_cycle();
      check_value({low_power_o, intr_wakeup_o}, 0, "low power or interrupt on fall-through");
    end
    check_value(wake_info_o.fall_through, 1, "fall_through flag");
    check_value(wake_info_o.reasons, v & en, "fall-through reasons");
    check_value(cfg_regwen_o, 1, "cfg_regwen_o after fall-through");
    core_sleeping_i  = 1'b0;
    low_power_hint_i = 1'b0;
    wakeups_i        = '0;
  endtask

  task automatic test_periph_sw_reset();
    logic [TotalRstReqs-1:0] cause;
    int high, lc, b;
    apply_reset();
    // masked requests do nothing
    rstreqs_i = '1;
    repeat (10) begin
      next_cycle();
      check_value(pwr_rst_o.rst_sys_req, 0, "reset from a disabled source");
    end
    rstreqs_i = '0;
    next_cycle();
    b = lcg_next() % NumRstReqs;
    reset_en_i   = 1 << b;
    rstreqs_i[b] = 1'b1;
    next_cycle();
    rstreqs_i = '0;
    measure_reset(high, lc, cause);
    check_value(high, RstHoldCycles, "peripheral reset hold length");
    check_value(lc, 0, "rst_lc_req on peripheral reset");
    check_value(cause, 1 << b, "peripheral reset cause");
    // software reset ignores the enables
    reset_en_i   = '0;
    sw_rst_req_i = 1'b1;
    next_cycle();
    sw_rst_req_i = 1'b0;
    measure_reset(high, lc, cause);
    check_value(high, RstHoldCycles, "software reset hold length");
    check_value(cause, 1 << RstSwIdx, "software reset cause");
    // debug reset through the synchronizer
    ndmreset_req_i = 1'b1;
    next_cycle();
    ndmreset_req_i = 1'b0;
    measure_reset(high, lc, cause);
    check_value(cause, 1 << RstNdmIdx, "debug reset cause");
    // reset out of low power
    enter_low_power();
    reset_en_i   = 1 << b;
    rstreqs_i[b] = 1'b1;
    next_cycle();
    rstreqs_i = '0;
    measure_reset(high, lc, cause);
    check_value(cause, 1 << b, "reset cause from low power");
    check_value(wake_info_o.abort, 1, "abort flag");
  endtask

  task automatic test_escalation();
    logic [TotalRstReqs-1:0] cause;
    int high, lc;
    apply_reset();
    esc_req_i = 1'b1;
    next_cycle();
    esc_req_i = 1'b0;
    // the latch holds, so the hold repeats
    repeat (3) begin
      measure_reset(high, lc, cause);
      check_value(high, RstHoldCycles, "escalation reset hold length");
      check_value(lc, RstHoldCycles, "rst_lc_req during escalation reset");
      check_value(cause, 1 << RstEscIdx, "escalation reset cause");
    end
    apply_reset();
    repeat (10) begin
      next_cycle();
      check_value(pwr_rst_o.rst_sys_req, 0, "escalation survived reset");
    end
  endtask

  task automatic test_heartbeat_timeout();
    logic [TotalRstReqs-1:0] cause;
    int high, lc, n;
    apply_reset();
    // regular pings keep the watchdog quiet well past its limit
    repeat (2 * EscTimeoutCnt) begin
      next_cycle();
      check_value({esc_timeout_o, pwr_rst_o.rst_sys_req}, 0, "timeout despite regular pings");
    end
    ping_en = 1'b0;
    n = 0;
    while (!esc_timeout_o) begin
      next_cycle();
      n++;
      if (n > EscTimeoutCnt + 4) timeout_abort("esc_timeout_o never rose without pings");
    end
    measure_reset(high, lc, cause);
    check_value(lc, RstHoldCycles, "rst_lc_req after heartbeat timeout");
    check_value(cause, 1 << RstEscIdx, "heartbeat timeout reset cause");
  endtask

  initial begin
    esc_ping_i = 1'b0;
    test_after_reset();
    test_sleep_wakeup();
    test_fall_through();
    test_periph_sw_reset();
    test_escalation();
    test_heartbeat_timeout();
    $display("sim passed");
    $finish;
  end

endmodule

// File: src/pwr_ctrl.sv
// power controller top: request capture and escalation monitor side by side,
// both feeding the fast FSM; the FSM clock enable arms the heartbeat watchdog
`timescale 1ns/1ps

module pwr_ctrl
  import pwr_ctrl_pkg::*;
(
  input  logic                    clk_i,
  input  logic                    effective_rst_n,
  // peripheral requests and enables
  input  logic [NumWkups-1:0]     wakeups_i,
  input  logic [NumRstReqs-1:0]   rstreqs_i,
  input  logic [NumWkups-1:0]     wakeup_en_i,
  input  logic [NumRstReqs-1:0]   reset_en_i,
  input  logic                    ndmreset_req_i,
  input  logic                    sw_rst_req_i,
  // escalation
  input  logic                    esc_req_i,
  input  logic                    esc_ping_i,
  output logic                    esc_timeout_o,
  // core side
  input  logic                    core_sleeping_i,
  input  logic                    low_power_hint_i,
  output logic                    clk_en_o,
  output logic                    low_power_o,
  output pwr_rst_t                pwr_rst_o,
  output logic                    intr_wakeup_o,
  output logic                    cfg_regwen_o,
  output wake_info_t              wake_info_o,
  output logic [TotalRstReqs-1:0] reset_cause_o
);

  pwr_peri_t peri_reqs;
  logic      esc_rst_req;

  pwr_req_capture u_capture (
    .clk_i          (clk_i),
    .effective_rst_n(effective_rst_n),
    .wakeups_i      (wakeups_i),
    .rstreqs_i      (rstreqs_i),
    .wakeup_en_i    (wakeup_en_i),
    .reset_en_i     (reset_en_i),
    .ndmreset_req_i (ndmreset_req_i),
    .sw_rst_req_i   (sw_rst_req_i),
    .peri_reqs_o    (peri_reqs)
  );

  // watchdog runs only while clocks are enabled
  pwr_esc_monitor u_esc (
    .clk_i          (clk_i),
    .effective_rst_n(effective_rst_n),
    .esc_req_i      (esc_req_i),
    .esc_ping_i     (esc_ping_i),
    .monitor_en_i   (clk_en_o),
    .esc_rst_req_o  (esc_rst_req),
    .esc_timeout_o  (esc_timeout_o)
  );

  pwr_fast_fsm u_fsm (
    .clk_i           (clk_i),
    .effective_rst_n (effective_rst_n),
    .peri_reqs_i     (peri_reqs),
    .esc_rst_req_i   (esc_rst_req),
    .core_sleeping_i (core_sleeping_i),
    .low_power_hint_i(low_power_hint_i),
    .clk_en_o        (clk_en_o),
    .low_power_o     (low_power_o),
    .pwr_rst_o       (pwr_rst_o),
    .intr_wakeup_o   (intr_wakeup_o),
    .cfg_regwen_o    (cfg_regwen_o),
    .wake_info_o     (wake_info_o),
    .reset_cause_o   (reset_cause_o)
  );

endmodule

// File: src/pwr_fast_fsm.sv
// fast power FSM: low-power entry and fall-through, wakeup with interrupt,
// reset hold sequencing, low-power config lock and wake/reset status capture
`timescale 1ns/1ps

module pwr_fast_fsm
  import pwr_ctrl_pkg::*;
(
  input  logic                    clk_i,
  input  logic                    effective_rst_n,
  input  pwr_peri_t               peri_reqs_i,
  input  logic                    esc_rst_req_i,
  input  logic                    core_sleeping_i,
  input  logic                    low_power_hint_i,
  output logic                    clk_en_o,
  output logic                    low_power_o,
  output pwr_rst_t                pwr_rst_o,
  output logic                    intr_wakeup_o,
  output logic                    cfg_regwen_o,
  output wake_info_t              wake_info_o,
  output logic [TotalRstReqs-1:0] reset_cause_o
);

  fast_state_e                state_q, state_d;
  logic [RstHoldCntWidth-1:0] hold_cnt_q;
  logic [TotalRstReqs-1:0]    rst_vec;
  logic [TotalRstReqs-1:0]    cause_q;
  logic                       any_rst;
  logic                       any_wkup;
  logic                       lp_entry;
  logic                       hold_done;
  logic                       enter_rst;
  logic                       fall_through;
  logic                       wkup;
  logic                       clk_en_q;
  logic                       low_power_q;
  logic                       lc_req_q;
  logic                       intr_q;
  logic                       regwen_q;
  logic                       hint_q;
  wake_info_t                 wake_info_q;

  //////////////////////////////
  // request decode
  //////////////////////////////

  // full reset vector, escalation slotted in between peripheral and debug
  always_comb begin
    rst_vec = '0;
    rst_vec[NumRstReqs-1:0] = peri_reqs_i.rstreqs[NumRstReqs-1:0];
    rst_vec[RstEscIdx]      = esc_rst_req_i;
    rst_vec[RstNdmIdx]      = peri_reqs_i.rstreqs[NumRstReqs];
    rst_vec[RstSwIdx]       = peri_reqs_i.rstreqs[NumRstReqs+1];
  end

  assign any_rst   = |rst_vec;
  assign any_wkup  = |peri_reqs_i.wakeups;
  assign lp_entry  = core_sleeping_i & low_power_hint_i;
  assign hold_done = hold_cnt_q == RstHoldCntWidth'(RstHoldCycles - 1);

  //////////////////////////////
  // next state
  //////////////////////////////

  // resets win over wakeups and entry
  always_comb begin
    state_d      = state_q;
    fall_through = 1'b0;
    wkup         = 1'b0;
    unique case (state_q)
      StActive: begin
        if (any_rst) begin
          state_d = StResetHold;
        end else if (lp_entry && any_wkup) begin
          // wakeup already pending, stay up
          fall_through = 1'b1;
        end else if (lp_entry) begin
          state_d = StLowPower;
        end
      end
      StLowPower: begin
        if (any_rst) begin
          state_d = StResetHold;
        end else if (any_wkup) begin
          state_d = StActive;
          wkup    = 1'b1;
        end
      end
      StResetHold: begin
        // back through active, which re-enters if a request remains
        if (hold_done) begin
          state_d = StActive;
        end
      end
      default: begin
        state_d = StActive;
      end
    endcase
  end

  assign enter_rst = (state_d == StResetHold) && (state_q != StResetHold);

  //////////////////////////////
  // state and output flops
  //////////////////////////////

  always_ff @(posedge clk_i or negedge effective_rst_n) begin
    if (!effective_rst_n) begin
      state_q     <= StActive;
      hold_cnt_q  <= '0;
      clk_en_q    <= 1'b1;
      low_power_q <= 1'b0;
      lc_req_q    <= 1'b0;
      intr_q      <= 1'b0;
    end else begin
      state_q     <= state_d;
      clk_en_q    <= state_d != StLowPower;
      low_power_q <= state_d == StLowPower;
      // one cycle pulse on the return to active
      intr_q      <= wkup;
      if (enter_rst) begin
        hold_cnt_q <= '0;
        // lc reset only for escalation
        lc_req_q   <= rst_vec[RstEscIdx];
      end else if (state_q == StResetHold) begin
        hold_cnt_q <= hold_cnt_q + 1'b1;
        if (hold_done) begin
          lc_req_q <= 1'b0;
        end
      end
    end
  end

  //////////////////////////////
  // status and config lock
  //////////////////////////////

  always_ff @(posedge clk_i or negedge effective_rst_n) begin
    if (!effective_rst_n) begin
      cause_q     <= '0;
      wake_info_q <= '0;
      regwen_q    <= 1'b1;
      hint_q      <= 1'b0;
    end else begin
      hint_q <= low_power_hint_i;
      if (enter_rst) begin
        cause_q <= rst_vec;
        // reset cut a low-power state short
        if (state_q == StLowPower) begin
          wake_info_q.abort <= 1'b1;
        end
      end else if (state_d == StLowPower && state_q == StActive) begin
        // fresh record for each low-power period
        wake_info_q <= '0;
      end else if (fall_through) begin
        wake_info_q.fall_through <= 1'b1;
        wake_info_q.reasons      <= peri_reqs_i.wakeups;
      end else if (wkup) begin
        wake_info_q.reasons <= peri_reqs_i.wakeups;
      end
      // lock on the hint's rising edge, reopen on wakeup or fall-through
      if (!regwen_q && (wkup || fall_through)) begin
        regwen_q <= 1'b1;
      end else if (low_power_hint_i && !hint_q) begin
        regwen_q <= 1'b0;
      end
    end
  end

  assign clk_en_o              = clk_en_q;
  assign low_power_o           = low_power_q;
  assign pwr_rst_o.rst_sys_req = state_q == StResetHold;
  assign pwr_rst_o.rst_lc_req  = lc_req_q;
  assign intr_wakeup_o         = intr_q;
  assign cfg_regwen_o          = regwen_q;
  assign wake_info_o           = wake_info_q;
  assign reset_cause_o         = cause_q;

  //////////////////////////////
  // assertions
  //////////////////////////////

  LowPowerClkEnExcl_A: assert property (
    @(posedge clk_i) disable iff (!effective_rst_n)
    !(low_power_o && clk_en_o)
  );

  LcReqImpliesSysReq_A: assert property (
    @(posedge clk_i) disable iff (!effective_rst_n)
    pwr_rst_o.rst_lc_req |-> pwr_rst_o.rst_sys_req
  );

endmodule

// File: src/pwr_esc_monitor.sv
// escalation reset path: a sticky latch for escalation requests plus a
// heartbeat watchdog, the two ORed into a single reset request for the FSM
`timescale 1ns/1ps

module pwr_esc_monitor
  import pwr_ctrl_pkg::*;
(
  input  logic clk_i,
  input  logic effective_rst_n,
  input  logic esc_req_i,
  // heartbeat pulse from the escalation sender
  input  logic esc_ping_i,
  // high while clocks are running
  input  logic monitor_en_i,
  output logic esc_rst_req_o,
  output logic esc_timeout_o
);

  logic                   esc_latch_q;
  logic [EscCntWidth-1:0] ping_cnt_q;
  logic                   timeout_q;
  logic                   cnt_last;

  //////////////////////////////
  // escalation latch
  //////////////////////////////

  // once set, only effective_rst_n clears it
  always_ff @(posedge clk_i or negedge effective_rst_n) begin
    if (!effective_rst_n) begin
      esc_latch_q <= 1'b0;
    end else if (esc_req_i) begin
      esc_latch_q <= 1'b1;
    end
  end

  //////////////////////////////
  // heartbeat watchdog
  //////////////////////////////

  assign cnt_last = ping_cnt_q == EscCntWidth'(EscTimeoutCnt - 1);

  always_ff @(posedge clk_i or negedge effective_rst_n) begin
    if (!effective_rst_n) begin
      ping_cnt_q <= '0;
      timeout_q  <= 1'b0;
    end else begin
      // no checking while clocks are gated
      if (!monitor_en_i || esc_ping_i) begin
        ping_cnt_q <= '0;
      end else if (!cnt_last) begin
        ping_cnt_q <= ping_cnt_q + 1'b1;
      end
      // sticky, dead path stays dead
      if (monitor_en_i && !esc_ping_i && cnt_last) begin
        timeout_q <= 1'b1;
      end
    end
  end

  assign esc_timeout_o = timeout_q;

  // a lost heartbeat is treated as an escalation
  assign esc_rst_req_o = esc_latch_q | timeout_q;

  //////////////////////////////
  // assertions
  //////////////////////////////

  EscLatchSticky_A: assert property (
    @(posedge clk_i) disable iff (!effective_rst_n)
    esc_latch_q |=> esc_latch_q
  );

endmodule

// File: src/pwr_req_capture.sv
// samples peripheral wakeup and reset pins and applies the software enables
// also brings in the debug reset through a 2-flop synchronizer and the sw reset
`timescale 1ns/1ps

module pwr_req_capture
  import pwr_ctrl_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  effective_rst_n,
  // request pins
  input  logic [NumWkups-1:0]   wakeups_i,
  input  logic [NumRstReqs-1:0] rstreqs_i,
  // software enables
  input  logic [NumWkups-1:0]   wakeup_en_i,
  input  logic [NumRstReqs-1:0] reset_en_i,
  // internal reset sources
  input  logic                  ndmreset_req_i,
  input  logic                  sw_rst_req_i,
  output pwr_peri_t             peri_reqs_o
);

  logic [NumWkups-1:0]   wkup_q;
  logic [NumRstReqs-1:0] rst_q;
  logic [1:0]            ndm_sync_q;
  logic                  sw_q;

  //////////////////////////////
  // input registers
  //////////////////////////////

  always_ff @(posedge clk_i or negedge effective_rst_n) begin
    if (!effective_rst_n) begin
      wkup_q     <= '0;
      rst_q      <= '0;
      ndm_sync_q <= '0;
      sw_q       <= 1'b0;
    end else begin
      // single stage for peripheral pins
      wkup_q     <= wakeups_i;
      rst_q      <= rstreqs_i;
      // debug request comes from another clock so it passes two stages
      ndm_sync_q <= {ndm_sync_q[0], ndmreset_req_i};
      sw_q       <= sw_rst_req_i;
    end
  end

  //////////////////////////////
  // masking
  //////////////////////////////

  // enables act on the registered value, so clearing one takes effect at once
  assign peri_reqs_o.wakeups = wkup_q & wakeup_en_i;

  // debug and sw requests cannot be masked
  assign peri_reqs_o.rstreqs = {sw_q, ndm_sync_q[1], rst_q & reset_en_i};

  //////////////////////////////
  // assertions
  //////////////////////////////

  // a set peripheral bit needs its enable now and its pin one cycle earlier
  MaskedReqsClear_A: assert property (
    @(posedge clk_i) disable iff (!effective_rst_n)
    ((peri_reqs_o.wakeups & ~(wakeup_en_i & $past(wakeups_i))) == '0) &&
    ((peri_reqs_o.rstreqs[NumRstReqs-1:0] & ~(reset_en_i & $past(rstreqs_i))) == '0)
  );

endmodule

// File: src/pwr_ctrl_pkg.sv
// shared sizes, request bit positions, FSM state and request structs
// for the single-clock power controller, imported by every block
package pwr_ctrl_pkg;

  //////////////////////////////
  // sizes
  //////////////////////////////

  // peripheral wakeup sources
  localparam int NumWkups = 4;
  // peripheral reset sources
  localparam int NumRstReqs = 2;
  // escalation, debug and software
  localparam int NumIntRstReqs = 3;
  localparam int TotalRstReqs = NumRstReqs + NumIntRstReqs;

  // positions in the full reset vector, peripherals sit below
  localparam int RstEscIdx = 2;
  localparam int RstNdmIdx = 3;
  localparam int RstSwIdx = 4;

  //////////////////////////////
  // timing
  //////////////////////////////

  // cycles without a heartbeat before the escalation path is dead
  localparam int EscTimeoutCnt = 128;
  localparam int EscCntWidth = 8;

  // reset request hold length and its counter width
  localparam int RstHoldCycles = 4;
  localparam int RstHoldCntWidth = $clog2(RstHoldCycles);

  //////////////////////////////
  // types
  //////////////////////////////

  // masked requests from capture to the FSM
  // rstreqs: peripheral bits, then debug, then software on top
  typedef struct packed {
    logic [NumWkups-1:0]     wakeups;
    logic [NumRstReqs+1:0]   rstreqs;
  } pwr_peri_t;

  // reset requests towards the reset manager
  typedef struct packed {
    logic rst_sys_req;
    logic rst_lc_req;
  } pwr_rst_t;

  // wake information
  typedef struct packed {
    logic [NumWkups-1:0] reasons;
    logic                fall_through;
    logic                abort;
  } wake_info_t;

  typedef enum logic [1:0] {
    StActive    = 2'd0,
    StLowPower  = 2'd1,
    StResetHold = 2'd2
  } fast_state_e;

endpackage
